//--- video_bus.f
+incdir+rtl
rtl/video_bus_pkg.sv
rtl/write_fifo.sv
rtl/cpu_port.sv
rtl/palette_lut.sv
rtl/vram_sequencer.sv
rtl/vram.sv
rtl/video_bus.sv
tests/video_checker.sv
tests/tb_video_bus.sv

//--- run_sim.sh
#!/bin/sh
# Builds the video_bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f video_bus.f --top-module tb_video_bus -o tb_video_bus
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_video_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "Simulation ended without a result line in $LOG"
	exit 1
fi

exit 0

//--- tests/tb_video_bus.sv
`timescale 1ns/1ns

`include "video_bus_settings.svh"

module tb_video_bus;

	localparam logic [31:0] PALETTE_BASE = `VB_PALETTE_BASE;
	localparam int LINE_GAP = 60;
	localparam int SCAN_LINES = 8;
	// Tests need about 8000 cycles
	localparam int CYCLE_LIMIT = 20000;

	logic clock;
	logic rst_n;
	video_bus_pkg::wb_req_t cpu_req;
	logic cpu_ack;
	logic video_request;
	logic [8:0] pos_x;
	logic [7:0] pos_y;
	logic [31:0] video_rgb;
	logic fifo_full;

	int pixel_errors;
	int protocol_errors;
	int pixel_checks;
	int sequence_errors = 0;
	int cycles;
	int acks_in_line;
	logic [31:0] probe_word;

	video_bus DUT (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_cpu(cpu_req),
		.o_cpu_ack(cpu_ack),
		.i_video_request(video_request),
		.i_video_pos_x(pos_x),
		.i_video_pos_y(pos_y),
		.o_video_rgb(video_rgb),
		.o_fifo_full(fifo_full)
	);

	video_checker u_checker (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_cpu(cpu_req),
		.i_cpu_ack(cpu_ack),
		.i_fifo_full(fifo_full),
		.i_video_request(video_request),
		.i_pos_x(pos_x),
		.i_pos_y(pos_y),
		.i_video_rgb(video_rgb),
		.o_pixel_errors(pixel_errors),
		.o_protocol_errors(protocol_errors),
		.o_pixel_checks(pixel_checks)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles = cycles + 1;
		end
		$display("Timeout: run stopped after %0d cycles", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// One Wishbone classic write, held until ack
	task automatic cpu_write(input logic [31:0] adr, input logic [31:0] dat, input logic we);
		video_bus_pkg::wb_req_t req;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = adr;
		req.dat = dat;
		@(posedge clock);
		cpu_req <= req;
		do
			@(posedge clock);
		while (!cpu_ack);
		cpu_req <= '0;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clock);
	endtask

	task automatic scan_line(input int y);
		for (int x = 0; x < `VB_FRAME_WIDTH; x++) begin
			@(posedge clock);
			video_request <= 1'b1;
			pos_x <= 9'(x);
			pos_y <= 8'(y);
		end
		@(posedge clock);
		video_request <= 1'b0;
		pos_x <= '0;
	endtask

	initial begin
		logic [31:0] data;
		int word;
		void'($urandom(32'h43d7de77));
		cpu_req = '0;
		video_request = 1'b0;
		pos_x = '0;
		pos_y = '0;
		rst_n = 1'b0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;

		// Idle outputs after reset, watched by the checker
		idle_cycles(4);

		// Known contents for every scanned VRAM word
		for (int w = 0; w < SCAN_LINES * `VB_WORDS_PER_LINE; w++) begin
			data = $urandom;
			if (w == 5)
				probe_word = data;
			cpu_write(32'(w) << 2, data, 1'b1);
		end

		// Full palette of random colours, then two lines
		for (int i = 0; i < 256; i++)
			cpu_write(PALETTE_BASE + (32'(i) << 2), $urandom, 1'b1);
		for (int y = 0; y < 2; y++) begin
			idle_cycles(LINE_GAP);
			scan_line(y);
		end

		// Random VRAM rewrites in blanking, lines 2 to 5
		for (int i = 0; i < 40; i++) begin
			word = 2 * `VB_WORDS_PER_LINE + int'($urandom_range(4 * `VB_WORDS_PER_LINE - 1));
			cpu_write(32'(word) << 2, $urandom, 1'b1);
		end
		for (int y = 2; y < 6; y++) begin
			idle_cycles(LINE_GAP);
			scan_line(y);
		end

		// Back-pressure: writes to line 7 while line 6 is on screen
		idle_cycles(LINE_GAP);
		acks_in_line = 0;
		fork
			scan_line(6);
			begin
				idle_cycles(4);
				for (int i = 0; i < 20; i++) begin
					word = 7 * `VB_WORDS_PER_LINE + int'($urandom_range(`VB_WORDS_PER_LINE - 1));
					cpu_write(32'(word) << 2, $urandom, 1'b1);
					if (video_request)
						acks_in_line++;
				end
			end
		join
		if (acks_in_line != `VB_FIFO_DEPTH) begin
			$display("Back-pressure failed: %0d writes were acknowledged during the line, not %0d",
				acks_in_line, `VB_FIFO_DEPTH);
			sequence_errors++;
		end
		idle_cycles(LINE_GAP);
		scan_line(7);
		idle_cycles(LINE_GAP);
		scan_line(6);

		// Reads must not touch a colour or a word that line 0 shows
		cpu_write(PALETTE_BASE + (32'(probe_word[15:8]) << 2), $urandom, 1'b0);
		cpu_write(32'd5 << 2, $urandom, 1'b0);
		idle_cycles(LINE_GAP);
		scan_line(0);
		idle_cycles(4);

		if (pixel_checks == 0) begin
			$display("No pixel was compared during the run");
			sequence_errors++;
		end
		$display("Errors: pixel %0d, protocol %0d, sequence %0d, over %0d pixel checks",
			pixel_errors, protocol_errors, sequence_errors, pixel_checks);
		if (pixel_errors + protocol_errors + sequence_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tests/video_checker.sv
`timescale 1ns/1ns

`include "video_bus_settings.svh"

module video_checker (
	input logic i_clock,
	input logic i_rst_n,
	input video_bus_pkg::wb_req_t i_cpu,
	input logic i_cpu_ack,
	input logic i_fifo_full,
	input logic i_video_request,
	input logic [8:0] i_pos_x,
	input logic [7:0] i_pos_y,
	input logic [31:0] i_video_rgb,
	output int o_pixel_errors,
	output int o_protocol_errors,
	output int o_pixel_checks
);

	localparam logic [31:0] PALETTE_BASE = `VB_PALETTE_BASE;

	// Images of VRAM and palette built from acknowledged CPU writes
	logic [31:0] vram_img [`VB_VRAM_WORDS];
	logic [31:0] pal_img [256];

	int pixel_errors = 0;
	int protocol_errors = 0;
	int pixel_checks = 0;
	int line_acks = 0;
	logic reset_prev = 1'b1;
	logic write_ack;
	logic vram_ack;

	assign write_ack = i_cpu.cyc && i_cpu.stb && i_cpu.we && i_cpu_ack;
	assign vram_ack = write_ack && (i_cpu.adr < PALETTE_BASE);
	assign o_pixel_errors = pixel_errors;
	assign o_protocol_errors = protocol_errors;
	assign o_pixel_checks = pixel_checks;

	// Pixel x of line y is byte x mod 4 of its VRAM word looked up in the palette
	function automatic logic [31:0] expected_pixel(input int x, input int y);
		int word_index;
		logic [31:0] word;
		logic [7:0] index;
		word_index = y * `VB_WORDS_PER_LINE + x / 4;
		word = vram_img[word_index[`VB_VRAM_AW-1:0]];
		index = 8'(word >> (8 * (x % 4)));
		return pal_img[index];
	endfunction

	always @(posedge i_clock) begin
		if (write_ack) begin
			if (i_cpu.adr >= PALETTE_BASE)
				pal_img[i_cpu.adr[9:2]] <= i_cpu.dat;
			else
				vram_img[i_cpu.adr[`VB_VRAM_AW+1:2]] <= i_cpu.dat;
		end
	end

	always @(posedge i_clock) begin
		logic [31:0] expected;
		if (i_rst_n && i_video_request && i_pos_x >= 4) begin
			expected = expected_pixel(int'(i_pos_x), int'(i_pos_y));
			pixel_checks <= pixel_checks + 1;
			if (i_video_rgb !== expected) begin
				$display("[FAIL] %0t: o_video_rgb at x=%0d y=%0d expected %h, seen %h",
					$time, i_pos_x, i_pos_y, expected, i_video_rgb);
				pixel_errors <= pixel_errors + 1;
			end
		end else if (!i_video_request && i_video_rgb !== 32'd0) begin
			$display("[FAIL] %0t: o_video_rgb in blanking expected %h, seen %h",
				$time, 32'd0, i_video_rgb);
			pixel_errors <= pixel_errors + 1;
		end
	end

	always @(posedge i_clock) begin
		reset_prev <= !i_rst_n;
		// First edge out of reset
		if (reset_prev && i_rst_n && (i_cpu_ack !== 1'b0 || i_fifo_full !== 1'b0)) begin
			$display("Error at %0t: CPU ack or FIFO full was set right after reset", $time);
			protocol_errors <= protocol_errors + 1;
		end
		if (i_rst_n && i_cpu_ack && !(i_cpu.cyc && i_cpu.stb)) begin
			$display("Error at %0t: CPU ack came without an active bus cycle", $time);
			protocol_errors <= protocol_errors + 1;
		end
		// Nothing drains during a line so each VRAM ack fills one slot
		if (!i_video_request) begin
			line_acks <= 0;
		end else begin
			if (i_fifo_full !== (line_acks >= `VB_FIFO_DEPTH)) begin
				$display("[FAIL] %0t: o_fifo_full expected %b, seen %b",
					$time, line_acks >= `VB_FIFO_DEPTH, i_fifo_full);
				protocol_errors <= protocol_errors + 1;
			end
			if (vram_ack) begin
				if (line_acks >= `VB_FIFO_DEPTH) begin
					$display("Error at %0t: VRAM write acknowledged while the FIFO was full",
						$time);
					protocol_errors <= protocol_errors + 1;
				end
				line_acks <= line_acks + 1;
			end
		end
	end

endmodule

//--- rtl/video_bus.sv
`timescale 1ns/1ns

module video_bus (
	input logic i_clock,
	input logic i_rst_n,
	input video_bus_pkg::wb_req_t i_cpu,
	output logic o_cpu_ack,
	input logic i_video_request,
	input logic [8:0] i_video_pos_x,
	input logic [7:0] i_video_pos_y,
	output logic [31:0] o_video_rgb,
	output logic o_fifo_full
);

	logic push;
	video_bus_pkg::fifo_entry_t push_data;
	logic pop;
	video_bus_pkg::fifo_entry_t pop_data;
	logic fifo_empty;

	logic pal_we;
	logic [7:0] pal_index;
	logic [31:0] pal_data;
	logic [31:0] quad;

	video_bus_pkg::wb_req_t mem_req;
	logic mem_ack;
	logic [31:0] mem_rdata;

	cpu_port u_cpu_port (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu(i_cpu),
		.o_cpu_ack(o_cpu_ack),
		.i_fifo_full(o_fifo_full),
		.o_push(push),
		.o_push_data(push_data),
		.o_pal_we(pal_we),
		.o_pal_index(pal_index),
		.o_pal_data(pal_data)
	);

	write_fifo u_write_fifo (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_push(push),
		.i_push_data(push_data),
		.i_pop(pop),
		.o_pop_data(pop_data),
		.o_empty(fifo_empty),
		.o_full(o_fifo_full)
	);

	// Pixel within the quad picks the byte
	palette_lut u_palette_lut (
		.i_clock(i_clock),
		.i_we(pal_we),
		.i_index(pal_index),
		.i_wdata(pal_data),
		.i_quad(quad),
		.i_byte_sel(i_video_pos_x[1:0]),
		.i_enable(i_video_request),
		.o_rgb(o_video_rgb)
	);

	vram_sequencer u_vram_sequencer (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_video_request(i_video_request),
		.i_pos_x(i_video_pos_x),
		.i_pos_y(i_video_pos_y),
		.i_fifo_empty(fifo_empty),
		.i_fifo_data(pop_data),
		.o_pop(pop),
		.o_mem(mem_req),
		.i_mem_ack(mem_ack),
		.i_mem_rdata(mem_rdata),
		.o_quad(quad)
	);

	vram u_vram (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_mem(mem_req),
		.o_ack(mem_ack),
		.o_rdata(mem_rdata)
	);

endmodule

//--- rtl/vram.sv
`timescale 1ns/1ns

`include "video_bus_settings.svh"

module vram (
	input logic i_clock,
	input logic i_rst_n,
	input video_bus_pkg::wb_req_t i_mem,
	output logic o_ack,
	output logic [31:0] o_rdata
);

	logic [31:0] words [`VB_VRAM_WORDS];
	logic [`VB_VRAM_AW-1:0] word_adr;
	logic access;

	assign word_adr = i_mem.adr[`VB_VRAM_AW-1:0];
	// One access per request, the ack cycle is not a new one
	assign access = i_mem.cyc && i_mem.stb && !o_ack;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			o_ack <= 1'b0;
		else
			o_ack <= access;
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_mem.we)
				words[word_adr] <= i_mem.dat;
			o_rdata <= words[word_adr];
		end
	end

	// CPU word indices and scan addresses must both land inside the frame buffer
	adr_in_range: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_mem.cyc && i_mem.stb) |-> (i_mem.adr < `VB_VRAM_WORDS))
		else $error("VRAM address beyond the frame buffer");

endmodule

//--- rtl/vram_sequencer.sv
`timescale 1ns/1ns

`include "video_bus_settings.svh"

module vram_sequencer (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_video_request,
	input logic [8:0] i_pos_x,
	input logic [7:0] i_pos_y,
	input logic i_fifo_empty,
	input video_bus_pkg::fifo_entry_t i_fifo_data,
	output logic o_pop,
	output video_bus_pkg::wb_req_t o_mem,
	input logic i_mem_ack,
	input logic [31:0] i_mem_rdata,
	output logic [31:0] o_quad
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_DRAIN,
		SEQ_FETCH,
		SEQ_HOLD
	} seq_state_t;

	seq_state_t state;

	video_bus_pkg::fifo_entry_t drain_entry;
	logic [31:0] fetch_adr;
	logic [31:0] next_quad;
	logic [31:0] quad;

	logic [9:0] x_ahead;
	logic [31:0] issue_adr;
	logic fetch_start;
	logic drain_start;
	logic fetch_ack;

	// Quad starting two pixels ahead of the current one
	assign x_ahead = {1'b0, i_pos_x} + 10'd2;
	assign issue_adr = 32'(i_pos_y) * 32'(`VB_WORDS_PER_LINE) + 32'(x_ahead[9:2]);

	assign fetch_start = (state == SEQ_IDLE) && i_video_request &&
		(x_ahead[1:0] == 2'd0) && (x_ahead < 10'(`VB_FRAME_WIDTH));
	assign drain_start = (state == SEQ_IDLE) && !i_video_request && !i_fifo_empty;
	assign fetch_ack = (state == SEQ_FETCH) && i_mem_ack;

	assign o_pop = drain_start;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= SEQ_IDLE;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (fetch_start)
						state <= SEQ_FETCH;
					else if (drain_start)
						state <= SEQ_DRAIN;
				end
				SEQ_DRAIN: begin
					// Finishes even if a line has started meanwhile
					if (i_mem_ack)
						state <= SEQ_IDLE;
				end
				SEQ_FETCH: begin
					if (i_mem_ack)
						state <= SEQ_HOLD;
				end
				default: begin
					// Wait until the quad boundary is behind us
					if (!i_video_request || i_pos_x[1:0] == 2'd0)
						state <= SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (drain_start)
			drain_entry <= i_fifo_data;
		if (fetch_start)
			fetch_adr <= issue_adr;
		if (fetch_ack)
			next_quad <= i_mem_rdata;
		// The word normally lands on the boundary edge itself
		if (i_video_request && i_pos_x[1:0] == 2'd3)
			quad <= fetch_ack ? i_mem_rdata : next_quad;
	end

	// Fetch goes out in the issuing pixel, then held from fetch_adr
	always_comb begin
		o_mem = '0;
		if (fetch_start) begin
			o_mem.cyc = 1'b1;
			o_mem.stb = 1'b1;
			o_mem.adr = issue_adr;
		end else if (state == SEQ_FETCH) begin
			o_mem.cyc = 1'b1;
			o_mem.stb = 1'b1;
			o_mem.adr = fetch_adr;
		end else if (state == SEQ_DRAIN) begin
			o_mem.cyc = 1'b1;
			o_mem.stb = 1'b1;
			o_mem.we = 1'b1;
			o_mem.adr = drain_entry.adr;
			o_mem.dat = drain_entry.dat;
		end
	end

	assign o_quad = quad;

	mem_req_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_mem.cyc && o_mem.stb && !i_mem_ack) |=>
		(o_mem.cyc && o_mem.stb && $stable(o_mem.we) &&
		$stable(o_mem.adr) && $stable(o_mem.dat)))
		else $error("VRAM request changed before acknowledge");

	scan_in_frame: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_video_request |->
		(i_pos_x < `VB_FRAME_WIDTH) && (i_pos_y < `VB_FRAME_HEIGHT))
		else $error("scan position outside the frame");

endmodule

//--- rtl/palette_lut.sv
`timescale 1ns/1ns

module palette_lut (
	input logic i_clock,
	input logic i_we,
	input logic [7:0] i_index,
	input logic [31:0] i_wdata,
	input logic [31:0] i_quad,
	input logic [1:0] i_byte_sel,
	input logic i_enable,
	output logic [31:0] o_rgb
);

	logic [31:0] colours [256];
	logic [7:0] lookup;

	always_ff @(posedge i_clock) begin
		if (i_we)
			colours[i_index] <= i_wdata;
	end

	// Byte 0 is the leftmost pixel of the quad
	always_comb begin
		case (i_byte_sel)
			2'd0: lookup = i_quad[7:0];
			2'd1: lookup = i_quad[15:8];
			2'd2: lookup = i_quad[23:16];
			default: lookup = i_quad[31:24];
		endcase
	end

	// Black outside the active line
	assign o_rgb = i_enable ? colours[lookup] : 32'd0;

endmodule

//--- rtl/cpu_port.sv
`timescale 1ns/1ns

`include "video_bus_settings.svh"

module cpu_port (
	input logic i_clock,
	input logic i_rst_n,
	input video_bus_pkg::wb_req_t i_cpu,
	output logic o_cpu_ack,
	input logic i_fifo_full,
	output logic o_push,
	output video_bus_pkg::fifo_entry_t o_push_data,
	output logic o_pal_we,
	output logic [7:0] o_pal_index,
	output logic [31:0] o_pal_data
);

	localparam logic [31:0] PALETTE_BASE = `VB_PALETTE_BASE;
	localparam logic [7:0] PALETTE_REGION = PALETTE_BASE[31:24];

	video_bus_pkg::cpu_addr_u cpu_addr;
	logic cycle_active;
	logic is_palette;

	assign cpu_addr = i_cpu.adr;
	assign cycle_active = i_cpu.cyc && i_cpu.stb;
	assign is_palette = (cpu_addr.vram.region >= PALETTE_REGION);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cpu_ack <= 1'b0;
			o_push <= 1'b0;
			o_pal_we <= 1'b0;
		end else begin
			o_cpu_ack <= 1'b0;
			o_push <= 1'b0;
			o_pal_we <= 1'b0;
			// Skip the cycle already being acknowledged
			if (cycle_active && !o_cpu_ack) begin
				if (!i_cpu.we) begin
					// Reads are not supported, just complete the cycle
					o_cpu_ack <= 1'b1;
				end else if (is_palette) begin
					o_cpu_ack <= 1'b1;
					o_pal_we <= 1'b1;
				end else if (!i_fifo_full) begin
					o_cpu_ack <= 1'b1;
					o_push <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		o_push_data.adr <= {10'd0, cpu_addr.vram.word};
		o_push_data.dat <= i_cpu.dat;
		o_pal_index <= cpu_addr.pal.index;
		o_pal_data <= i_cpu.dat;
	end

	single_ack: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_cpu_ack |=> !o_cpu_ack)
		else $error("CPU ack held for more than one cycle");

endmodule

//--- rtl/write_fifo.sv
`timescale 1ns/1ns

`include "video_bus_settings.svh"

module write_fifo (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_push,
	input video_bus_pkg::fifo_entry_t i_push_data,
	input logic i_pop,
	output video_bus_pkg::fifo_entry_t o_pop_data,
	output logic o_empty,
	output logic o_full
);

	localparam int PW = $clog2(`VB_FIFO_DEPTH);
	localparam logic [PW:0] FULL_COUNT = `VB_FIFO_DEPTH;

	video_bus_pkg::fifo_entry_t entries [`VB_FIFO_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap naturally, depth is a power of two
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push)
			entries[wr_ptr] <= i_push_data;
	end

	// Head entry shows through while not empty
	assign o_pop_data = entries[rd_ptr];
	assign o_empty = (count == '0);
	assign o_full = (count == FULL_COUNT);

	no_overflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_push |-> !o_full)
		else $error("write FIFO pushed while full");

	no_underflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_pop |-> !o_empty)
		else $error("write FIFO popped while empty");

endmodule

//--- rtl/video_bus_pkg.sv
package video_bus_pkg;

	// Wishbone classic master request
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [30:0] spare;
	} wb_req_t;

	// VRAM word address and data waiting in the write FIFO
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
	} fifo_entry_t;

	typedef struct packed {
		logic [7:0] region;
		logic [21:0] word;
		logic [1:0] byte_off;
	} cpu_vram_addr_t;

	typedef struct packed {
		logic [7:0] region;
		logic [13:0] unused;
		logic [7:0] index;
		logic [1:0] byte_off;
	} cpu_pal_addr_t;

	// Region zero selects VRAM, anything above selects the palette
	typedef union packed {
		cpu_vram_addr_t vram;
		cpu_pal_addr_t pal;
	} cpu_addr_u;

endpackage

//--- rtl/video_bus_settings.svh
`ifndef VIDEO_BUS_SETTINGS_SVH
`define VIDEO_BUS_SETTINGS_SVH

// Visible frame in pixels
`define VB_FRAME_WIDTH 320
`define VB_FRAME_HEIGHT 240

// Four 8-bit pixel indices per VRAM word
`define VB_WORDS_PER_LINE 80

// VRAM geometry, one word per quad
`define VB_VRAM_WORDS 19200
`define VB_VRAM_AW 15

// Pending CPU writes to VRAM
`define VB_FIFO_DEPTH 16

// CPU byte addresses from here up hit the palette
`define VB_PALETTE_BASE 32'h0100_0000

`endif
